// ==== mfp_reset_gen.sv ====
`timescale 1ns/1ps

module mfp_reset_gen
#(
    parameter int RESET_HOLD = 16
)
(
    input  logic clk,
    input  logic reset,
    input  logic soft_reset_req,
    output logic periph_reset
);

    localparam int CNT_W = $clog2(RESET_HOLD + 1);

    logic [CNT_W-1:0] hold_cnt;

    // retriggerable hold, reloaded by either reset source
    always_ff @(posedge clk)
    begin
        if (reset || soft_reset_req)
            hold_cnt <= CNT_W'(RESET_HOLD);
        else if (hold_cnt != '0)
            hold_cnt <= hold_cnt - 1'b1;
    end

    assign periph_reset = (hold_cnt != '0);

endmodule

// ==== mfp_pkg.sv ====
package mfp_pkg;

    // bus transfer type, only the two kinds this bus uses
    typedef enum logic [1:0]
    {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_t;

    // light sensor receiver states
    typedef enum logic [1:0]
    {
        ALS_IDLE  = 2'b00,
        ALS_SHIFT = 2'b01,
        ALS_GAP   = 2'b10
    } als_state_t;

    // register window, upper 24 bits are compared
    localparam logic [31:0] GPIO_BASE = 32'h1f80_0000;

    // register offsets inside the window
    localparam logic [7:0] ADDR_RED_LEDS     = 8'h00;
    localparam logic [7:0] ADDR_GREEN_LEDS   = 8'h04;
    localparam logic [7:0] ADDR_SWITCHES     = 8'h08;
    localparam logic [7:0] ADDR_BUTTONS      = 8'h0C;
    localparam logic [7:0] ADDR_LIGHT_SENSOR = 8'h10;
    localparam logic [7:0] ADDR_SOFT_RESET   = 8'h14;

    // board i/o widths
    localparam int RED_LED_W   = 18;
    localparam int GREEN_LED_W = 9;
    localparam int SWITCH_W    = 18;
    localparam int BUTTON_W    = 5;
    localparam int ALS_W       = 16;

endpackage

// ==== mfp_ahb_gpio.sv ====
`timescale 1ns/1ps

module mfp_ahb_gpio
(
    input  logic                             clk,
    input  logic                             periph_reset,
    input  logic                             red_we,
    input  logic                             green_we,
    input  logic [31:0]                      wdata,
    input  logic [mfp_pkg::SWITCH_W-1:0]     io_switches,
    input  logic [mfp_pkg::BUTTON_W-1:0]     io_buttons,
    output logic [mfp_pkg::RED_LED_W-1:0]    red_leds,
    output logic [mfp_pkg::GREEN_LED_W-1:0]  green_leds,
    output logic [mfp_pkg::SWITCH_W-1:0]     switches_sync,
    output logic [mfp_pkg::BUTTON_W-1:0]     buttons_sync
);

    logic [mfp_pkg::SWITCH_W-1:0] switches_meta;
    logic [mfp_pkg::BUTTON_W-1:0] buttons_meta;

    // led registers, writes are dropped while the peripheral reset is held
    always_ff @(posedge clk)
    begin
        if (periph_reset)
        begin
            red_leds   <= '0;
            green_leds <= '0;
        end
        else
        begin
            if (red_we)
                red_leds <= wdata[mfp_pkg::RED_LED_W-1:0];
            if (green_we)
                green_leds <= wdata[mfp_pkg::GREEN_LED_W-1:0];
        end
    end

    // two-flop synchronizers for the asynchronous board inputs
    always_ff @(posedge clk)
    begin
        switches_meta <= io_switches;
        switches_sync <= switches_meta;
        buttons_meta  <= io_buttons;
        buttons_sync  <= buttons_meta;
    end

endmodule

// ==== mfp_pmod_als_spi_receiver.sv ====
`timescale 1ns/1ps

module mfp_pmod_als_spi_receiver
#(
    parameter int SPI_HALF_PERIOD = 4
)
(
    input  logic                       clk,
    input  logic                       periph_reset,
    output logic                       spi_cs,
    output logic                       spi_sck,
    input  logic                       spi_sdo,
    output logic [mfp_pkg::ALS_W-1:0]  als_value
);

    localparam int HC_W = $clog2(SPI_HALF_PERIOD + 1);

    mfp_pkg::als_state_t        state;
    logic [HC_W-1:0]            half_cnt;
    logic [3:0]                 bit_cnt;
    logic [mfp_pkg::ALS_W-1:0]  shift_reg;
    logic                       half_end;

    assign half_end = (half_cnt == HC_W'(SPI_HALF_PERIOD - 1));

    // each sck period is low for one half, then high for one half;
    // data is taken on the rising edge, msb first
    always_ff @(posedge clk)
    begin
        if (periph_reset)
        begin
            state     <= mfp_pkg::ALS_IDLE;
            spi_cs    <= 1'b1;
            spi_sck   <= 1'b1;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            als_value <= '0;
        end
        else
        begin
            half_cnt <= half_end ? '0 : half_cnt + 1'b1;

            case (state)
                mfp_pkg::ALS_IDLE:
                begin
                    // first frame starts right after reset
                    state    <= mfp_pkg::ALS_SHIFT;
                    spi_cs   <= 1'b0;
                    spi_sck  <= 1'b0;
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                end

                mfp_pkg::ALS_SHIFT:
                begin
                    if (half_end)
                    begin
                        if (!spi_sck)
                        begin
                            spi_sck   <= 1'b1;
                            shift_reg <= {shift_reg[mfp_pkg::ALS_W-2:0], spi_sdo};
                        end
                        else if (bit_cnt == 4'd15)
                        begin
                            // frame done, sck stays high through the gap
                            state   <= mfp_pkg::ALS_GAP;
                            spi_cs  <= 1'b1;
                            bit_cnt <= '0;
                        end
                        else
                        begin
                            spi_sck <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                mfp_pkg::ALS_GAP:
                begin
                    // first gap cycle publishes the completed frame
                    if (half_cnt == '0 && bit_cnt == '0)
                        als_value <= shift_reg;

                    // gap spans two half periods, counted in bit_cnt[0]
                    if (half_end)
                    begin
                        if (bit_cnt[0])
                        begin
                            state   <= mfp_pkg::ALS_SHIFT;
                            spi_cs  <= 1'b0;
                            spi_sck <= 1'b0;
                            bit_cnt <= '0;
                        end
                        else
                            bit_cnt <= 4'd1;
                    end
                end

                default:
                    state <= mfp_pkg::ALS_IDLE;
            endcase
        end
    end

endmodule

// ==== mfp_ahb_lite_matrix.sv ====
`timescale 1ns/1ps

module mfp_ahb_lite_matrix
(
    input  logic                             clk,
    input  logic                             reset,
    input  mfp_pkg::htrans_t                 htrans,
    input  logic [31:0]                      haddr,
    input  logic                             hwrite,
    input  logic [31:0]                      hwdata,
    output logic [31:0]                      hrdata,
    output logic                             red_we,
    output logic                             green_we,
    output logic [31:0]                      gpio_wdata,
    input  logic [mfp_pkg::RED_LED_W-1:0]    red_leds,
    input  logic [mfp_pkg::GREEN_LED_W-1:0]  green_leds,
    input  logic [mfp_pkg::SWITCH_W-1:0]     switches_sync,
    input  logic [mfp_pkg::BUTTON_W-1:0]     buttons_sync,
    input  logic [mfp_pkg::ALS_W-1:0]        als_value,
    output logic                             soft_reset_req
);

    logic        dp_valid;
    logic        dp_hit;
    logic        dp_write;
    logic [7:0]  dp_offset;
    logic        wr_access;
    logic        rd_access;

    // address phase capture, valid flag is the only control state
    always_ff @(posedge clk)
    begin
        if (reset)
            dp_valid <= 1'b0;
        else
            dp_valid <= (htrans == mfp_pkg::HTRANS_NONSEQ);
    end

    always_ff @(posedge clk)
    begin
        dp_hit    <= (haddr[31:8] == mfp_pkg::GPIO_BASE[31:8]);
        dp_write  <= hwrite;
        dp_offset <= haddr[7:0];
    end

    // data phase
    assign wr_access = dp_valid && dp_hit && dp_write;
    assign rd_access = dp_valid && dp_hit && !dp_write;

    assign red_we     = wr_access && (dp_offset == mfp_pkg::ADDR_RED_LEDS);
    assign green_we   = wr_access && (dp_offset == mfp_pkg::ADDR_GREEN_LEDS);
    assign gpio_wdata = hwdata;

    // software reset strobe, one cycle after the data phase
    always_ff @(posedge clk)
    begin
        if (reset)
            soft_reset_req <= 1'b0;
        else
            soft_reset_req <= wr_access
                              && (dp_offset == mfp_pkg::ADDR_SOFT_RESET)
                              && hwdata[0];
    end

    // read mux, anything unmapped returns zero
    always_comb
    begin
        hrdata = '0;
        if (rd_access)
        begin
            case (dp_offset)
                mfp_pkg::ADDR_RED_LEDS:     hrdata = 32'(red_leds);
                mfp_pkg::ADDR_GREEN_LEDS:   hrdata = 32'(green_leds);
                mfp_pkg::ADDR_SWITCHES:     hrdata = 32'(switches_sync);
                mfp_pkg::ADDR_BUTTONS:      hrdata = 32'(buttons_sync);
                mfp_pkg::ADDR_LIGHT_SENSOR: hrdata = 32'(als_value);
                default:                    hrdata = '0;
            endcase
        end
    end

endmodule

// ==== mfp_system.sv ====
`timescale 1ns/1ps

module mfp_system
#(
    parameter int SPI_HALF_PERIOD = 4,
    parameter int RESET_HOLD      = 16
)
(
    input  logic                             clk,
    input  logic                             reset,

    input  mfp_pkg::htrans_t                 HTRANS,
    input  logic [31:0]                      HADDR,
    input  logic                             HWRITE,
    input  logic [31:0]                      HWDATA,
    output logic [31:0]                      HRDATA,

    input  logic [mfp_pkg::SWITCH_W-1:0]     IO_Switches,
    input  logic [mfp_pkg::BUTTON_W-1:0]     IO_Buttons,
    output logic [mfp_pkg::RED_LED_W-1:0]    IO_RedLEDs,
    output logic [mfp_pkg::GREEN_LED_W-1:0]  IO_GreenLEDs,

    output logic                             SPI_CS,
    output logic                             SPI_SCK,
    input  logic                             SPI_SDO
);

    logic                             periph_reset;
    logic                             soft_reset_req;
    logic                             red_we;
    logic                             green_we;
    logic [31:0]                      gpio_wdata;
    logic [mfp_pkg::SWITCH_W-1:0]     switches_sync;
    logic [mfp_pkg::BUTTON_W-1:0]     buttons_sync;
    logic [mfp_pkg::ALS_W-1:0]        als_value;

    mfp_reset_gen
    #(
        .RESET_HOLD ( RESET_HOLD )
    )
    i_reset_gen
    (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .soft_reset_req ( soft_reset_req ),
        .periph_reset   ( periph_reset   )
    );

    // bus side runs on the external reset only
    mfp_ahb_lite_matrix i_matrix
    (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .htrans         ( HTRANS         ),
        .haddr          ( HADDR          ),
        .hwrite         ( HWRITE         ),
        .hwdata         ( HWDATA         ),
        .hrdata         ( HRDATA         ),
        .red_we         ( red_we         ),
        .green_we       ( green_we       ),
        .gpio_wdata     ( gpio_wdata     ),
        .red_leds       ( IO_RedLEDs     ),
        .green_leds     ( IO_GreenLEDs   ),
        .switches_sync  ( switches_sync  ),
        .buttons_sync   ( buttons_sync   ),
        .als_value      ( als_value      ),
        .soft_reset_req ( soft_reset_req )
    );

    mfp_ahb_gpio i_gpio
    (
        .clk           ( clk           ),
        .periph_reset  ( periph_reset  ),
        .red_we        ( red_we        ),
        .green_we      ( green_we      ),
        .wdata         ( gpio_wdata    ),
        .io_switches   ( IO_Switches   ),
        .io_buttons    ( IO_Buttons    ),
        .red_leds      ( IO_RedLEDs    ),
        .green_leds    ( IO_GreenLEDs  ),
        .switches_sync ( switches_sync ),
        .buttons_sync  ( buttons_sync  )
    );

    mfp_pmod_als_spi_receiver
    #(
        .SPI_HALF_PERIOD ( SPI_HALF_PERIOD )
    )
    i_als_receiver
    (
        .clk          ( clk          ),
        .periph_reset ( periph_reset ),
        .spi_cs       ( SPI_CS       ),
        .spi_sck      ( SPI_SCK      ),
        .spi_sdo      ( SPI_SDO      ),
        .als_value    ( als_value    )
    );

endmodule

// ==== mfp_system_assertions.sv ====
`timescale 1ns/1ps

module mfp_system_assertions
(
    input logic             clk,
    input logic             reset,
    input mfp_pkg::htrans_t htrans,
    input logic             spi_cs,
    input logic             spi_sck,
    input logic             soft_reset_req,
    input logic             periph_reset
);

    int fail_count = 0;

    htrans_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(htrans))
    else
    begin
        fail_count++;
        $error("HTRANS is unknown after reset");
    end

    // sck idles high between frames
    sck_idle_high: assert property (@(posedge clk) disable iff (reset) spi_cs |-> spi_sck)
    else
    begin
        fail_count++;
        $error("SPI_SCK low while SPI_CS is high");
    end

    soft_reset_takes: assert property (@(posedge clk) disable iff (reset)
        soft_reset_req |=> periph_reset)
    else
    begin
        fail_count++;
        $error("periph_reset did not follow soft_reset_req");
    end

endmodule

bind mfp_system mfp_system_assertions i_assertions
(
    .clk            ( clk            ),
    .reset          ( reset          ),
    .htrans         ( HTRANS         ),
    .spi_cs         ( SPI_CS         ),
    .spi_sck        ( SPI_SCK        ),
    .soft_reset_req ( soft_reset_req ),
    .periph_reset   ( periph_reset   )
);

// ==== tb_als_model.sv ====
`timescale 1ns/1ps

module tb_als_model
(
    input  logic                      clk,
    input  logic                      spi_cs,
    input  logic                      spi_sck,
    output logic                      spi_sdo,
    output logic [mfp_pkg::ALS_W-1:0] last_word
);

    logic [31:0]               lfsr_state = 32'h7d783b2a;
    logic [31:0]               fresh;
    logic [mfp_pkg::ALS_W-1:0] sent_word = '0;
    logic [mfp_pkg::ALS_W-1:0] shift_word = '0;
    logic [mfp_pkg::ALS_W-1:0] recorded = '0;
    logic                      sdo_bit = 1'b0;
    logic                      cs_q = 1'b1;
    logic                      sck_q = 1'b1;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // cs and sck only move on rising clk, so they are steady here
    always @(negedge clk)
    begin
        if (cs_q && !spi_cs)
        begin
            fresh      = next_bits(mfp_pkg::ALS_W);
            sent_word  = fresh[mfp_pkg::ALS_W-1:0];
            sdo_bit    = sent_word[mfp_pkg::ALS_W-1];
            shift_word = sent_word << 1;
        end
        else if (!spi_cs && sck_q && !spi_sck)
        begin
            sdo_bit    = shift_word[mfp_pkg::ALS_W-1];
            shift_word = shift_word << 1;
        end
        else if (!cs_q && spi_cs)
            recorded = sent_word;
        cs_q  = spi_cs;
        sck_q = spi_sck;
    end

    assign spi_sdo   = sdo_bit;
    assign last_word = recorded;

endmodule

// ==== tb_mfp_system.sv ====
`timescale 1ns/1ps

module tb_mfp_system;

    localparam int SPI_HALF_PERIOD = 4;
    localparam int RESET_HOLD      = 16;
    localparam int FRAME_CYCLES    = 36 * SPI_HALF_PERIOD;
    localparam int BUS_CYCLES      = 140;
    // bus tests, three sensor frames, reset and two holds, plus half again
    localparam int WATCHDOG_CYCLES =
        (BUS_CYCLES + 3 * FRAME_CYCLES + 10 + 2 * RESET_HOLD) * 3 / 2;

    logic                                clk;
    logic                                reset;
    mfp_pkg::htrans_t                    HTRANS;
    logic [31:0]                         HADDR;
    logic                                HWRITE;
    logic [31:0]                         HWDATA;
    logic [31:0]                         HRDATA;
    logic [mfp_pkg::SWITCH_W-1:0]        IO_Switches;
    logic [mfp_pkg::BUTTON_W-1:0]        IO_Buttons;
    logic [mfp_pkg::RED_LED_W-1:0]       IO_RedLEDs;
    logic [mfp_pkg::GREEN_LED_W-1:0]     IO_GreenLEDs;
    logic                                SPI_CS;
    logic                                SPI_SCK;
    logic                                SPI_SDO;
    logic [mfp_pkg::ALS_W-1:0]           model_word;
    logic [31:0]                         lfsr_state;
    int                                  errors;
    int                                  checks;

    mfp_system
    #(
        .SPI_HALF_PERIOD ( SPI_HALF_PERIOD ),
        .RESET_HOLD      ( RESET_HOLD      )
    )
    i_dut
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .HTRANS       ( HTRANS       ),
        .HADDR        ( HADDR        ),
        .HWRITE       ( HWRITE       ),
        .HWDATA       ( HWDATA       ),
        .HRDATA       ( HRDATA       ),
        .IO_Switches  ( IO_Switches  ),
        .IO_Buttons   ( IO_Buttons   ),
        .IO_RedLEDs   ( IO_RedLEDs   ),
        .IO_GreenLEDs ( IO_GreenLEDs ),
        .SPI_CS       ( SPI_CS       ),
        .SPI_SCK      ( SPI_SCK      ),
        .SPI_SDO      ( SPI_SDO      )
    );

    tb_als_model i_als_model
    (
        .clk       ( clk        ),
        .spi_cs    ( SPI_CS     ),
        .spi_sck   ( SPI_SCK    ),
        .spi_sdo   ( SPI_SDO    ),
        .last_word ( model_word )
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [7:0] offset);
        return {mfp_pkg::GPIO_BASE[31:8], offset};
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        HTRANS = mfp_pkg::HTRANS_NONSEQ;
        HADDR  = addr;
        HWRITE = 1'b1;
        @(negedge clk);
        HTRANS = mfp_pkg::HTRANS_IDLE;
        HWRITE = 1'b0;
        HWDATA = data;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        HTRANS = mfp_pkg::HTRANS_NONSEQ;
        HADDR  = addr;
        HWRITE = 1'b0;
        @(negedge clk);
        HTRANS = mfp_pkg::HTRANS_IDLE;
        // same value the closing rising edge sees
        data = HRDATA;
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_red(input logic [mfp_pkg::RED_LED_W-1:0] expected);
        checks++;
        if (IO_RedLEDs !== expected)
        begin
            errors++;
            $display("FAILED at %0t: IO_RedLEDs expected %h, got %h",
                     $time, expected, IO_RedLEDs);
        end
    endtask

    task automatic check_green(input logic [mfp_pkg::GREEN_LED_W-1:0] expected);
        checks++;
        if (IO_GreenLEDs !== expected)
        begin
            errors++;
            $display("FAILED at %0t: IO_GreenLEDs expected %h, got %h",
                     $time, expected, IO_GreenLEDs);
        end
    endtask

    task automatic check_als(input logic [mfp_pkg::ALS_W-1:0] expected,
                             input logic [mfp_pkg::ALS_W-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at %0t: als_value expected %h, got %h", $time, expected, actual);
        end
    endtask

    task automatic test_led_write();
        logic [31:0]                     red_word;
        logic [31:0]                     green_word;
        logic [31:0]                     rd;
        int                              n;
        for (n = 0; n < 4; n++)
        begin
            red_word   = next_bits(32);
            green_word = next_bits(32);
            bus_write(reg_addr(mfp_pkg::ADDR_RED_LEDS), red_word);
            @(negedge clk);
            check_red(red_word[mfp_pkg::RED_LED_W-1:0]);
            bus_write(reg_addr(mfp_pkg::ADDR_GREEN_LEDS), green_word);
            @(negedge clk);
            check_green(green_word[mfp_pkg::GREEN_LED_W-1:0]);
            bus_read(reg_addr(mfp_pkg::ADDR_RED_LEDS), rd);
            check_word("HRDATA red", 32'(red_word[mfp_pkg::RED_LED_W-1:0]), rd);
            bus_read(reg_addr(mfp_pkg::ADDR_GREEN_LEDS), rd);
            check_word("HRDATA green", 32'(green_word[mfp_pkg::GREEN_LED_W-1:0]), rd);
        end
    endtask

    task automatic test_inputs();
        logic [31:0] sw_word;
        logic [31:0] btn_word;
        logic [31:0] rd;
        int          n;
        for (n = 0; n < 4; n++)
        begin
            sw_word  = next_bits(mfp_pkg::SWITCH_W);
            btn_word = next_bits(mfp_pkg::BUTTON_W);
            @(negedge clk);
            IO_Switches = sw_word[mfp_pkg::SWITCH_W-1:0];
            IO_Buttons  = btn_word[mfp_pkg::BUTTON_W-1:0];
            // two synchronizer flops plus margin
            repeat (3) @(negedge clk);
            bus_read(reg_addr(mfp_pkg::ADDR_SWITCHES), rd);
            check_word("HRDATA switches", sw_word, rd);
            bus_read(reg_addr(mfp_pkg::ADDR_BUTTONS), rd);
            check_word("HRDATA buttons", btn_word, rd);
        end
    endtask

    task automatic test_decode();
        logic [mfp_pkg::RED_LED_W-1:0]   red_before;
        logic [mfp_pkg::GREEN_LED_W-1:0] green_before;
        logic [31:0]                     outside;
        logic [31:0]                     rd;
        red_before   = IO_RedLEDs;
        green_before = IO_GreenLEDs;
        outside      = reg_addr(mfp_pkg::ADDR_RED_LEDS) ^ 32'h0100_0000;
        bus_read(reg_addr(8'h18), rd);
        check_word("HRDATA unused offset", '0, rd);
        bus_read(outside, rd);
        check_word("HRDATA outside window", '0, rd);
        bus_write(reg_addr(8'h18), next_bits(32));
        bus_write(outside, next_bits(32));
        bus_write(outside ^ 32'(mfp_pkg::ADDR_GREEN_LEDS), next_bits(32));
        @(negedge clk);
        check_red(red_before);
        check_green(green_before);
    endtask

    task automatic test_light_sensor();
        logic [31:0] rd;
        @(posedge SPI_CS);
        @(posedge SPI_CS);
        repeat (2) @(negedge clk);
        bus_read(reg_addr(mfp_pkg::ADDR_LIGHT_SENSOR), rd);
        check_als(model_word, rd[mfp_pkg::ALS_W-1:0]);
        check_word("HRDATA sensor upper bits", '0, rd >> mfp_pkg::ALS_W);
    endtask

    task automatic test_soft_reset();
        logic [31:0] value;
        logic [31:0] rd;
        bus_write(reg_addr(mfp_pkg::ADDR_RED_LEDS), next_bits(32) | 32'h1);
        bus_write(reg_addr(mfp_pkg::ADDR_GREEN_LEDS), next_bits(32) | 32'h1);
        bus_write(reg_addr(mfp_pkg::ADDR_SOFT_RESET), 32'h1);
        repeat (3) @(negedge clk);
        check_red('0);
        check_green('0);
        // write lands inside the hold and is dropped
        bus_write(reg_addr(mfp_pkg::ADDR_RED_LEDS), next_bits(32) | 32'h1);
        @(negedge clk);
        check_red('0);
        bus_read(reg_addr(mfp_pkg::ADDR_RED_LEDS), rd);
        check_word("HRDATA red during hold", '0, rd);
        repeat (RESET_HOLD) @(negedge clk);
        value = next_bits(32) | 32'h1;
        bus_write(reg_addr(mfp_pkg::ADDR_RED_LEDS), value);
        bus_read(reg_addr(mfp_pkg::ADDR_RED_LEDS), rd);
        check_word("HRDATA red after hold", 32'(value[mfp_pkg::RED_LED_W-1:0]), rd);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        lfsr_state  = 32'h7d783b2a;
        errors      = 0;
        checks      = 0;
        reset       = 1'b1;
        HTRANS      = mfp_pkg::HTRANS_IDLE;
        HADDR       = '0;
        HWRITE      = 1'b0;
        HWDATA      = '0;
        IO_Switches = '0;
        IO_Buttons  = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        // peripheral reset runs on for its hold
        repeat (RESET_HOLD + 2) @(negedge clk);
        test_led_write();
        test_inputs();
        test_decode();
        test_light_sensor();
        test_soft_reset();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_dut.i_assertions.fail_count);
        if (errors == 0 && i_dut.i_assertions.fail_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
mfp_reset_gen.sv
mfp_pkg.sv
mfp_ahb_gpio.sv
mfp_pmod_als_spi_receiver.sv
mfp_ahb_lite_matrix.sv
mfp_system.sv
mfp_system_assertions.sv
tb_als_model.sv
tb_mfp_system.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mfp_system
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
